//--- Makefile
RTL := verilog/usb_rx_pkg.sv verilog/ulpi_rx_decode.sv verilog/usb_crc16.sv \
       verilog/usb_packet_exec.sv verilog/usb_bulk_out_buffer.sv verilog/usb_rx_core.sv

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/Vusb_rx_core_tb)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

build:
	verilator --binary --timing --assert -f files.f --top-module usb_rx_core_tb

lint:
	verilator --lint-only -Wall +incdir+verilog $(RTL) --top-module usb_rx_core

clean:
	rm -rf obj_dir

//--- bench/usb_rx_core_properties.sv
`timescale 1ns/10ps

module usb_rx_core_properties (
  input logic       ulpi_clock_i,
  input logic       arst_n_i,
  input logic       blko_tvalid_i,
  input logic       blko_tready_i,
  input logic       blko_tlast_i,
  input logic [7:0] blko_tdata_i,
  input logic       crc_error_i,
  input logic       overflow_i
);

  // AXI4-Stream payload holds while the sink stalls
  stream_hold: assert property (@(posedge ulpi_clock_i) disable iff (!arst_n_i)
    blko_tvalid_i && !blko_tready_i |=> $stable(blko_tdata_i) && $stable(blko_tlast_i))
    else $error("stream data or tlast changed during a stall");

  crc_pulse: assert property (@(posedge ulpi_clock_i) disable iff (!arst_n_i)
    crc_error_i |=> !crc_error_i)
    else $error("crc error flag held longer than one cycle");

  ov_pulse: assert property (@(posedge ulpi_clock_i) disable iff (!arst_n_i)
    overflow_i |=> !overflow_i)
    else $error("overflow flag held longer than one cycle");

  reset_idle: assert property (@(posedge ulpi_clock_i) !arst_n_i |-> !blko_tvalid_i)
    else $error("tvalid high during reset");

endmodule

bind usb_rx_core usb_rx_core_properties usb_rx_core_properties_inst (
  .ulpi_clock_i (ulpi_clock_i),
  .arst_n_i     (arst_n_i),
  .blko_tvalid_i(blko_tvalid_o),
  .blko_tready_i(blko_tready_i),
  .blko_tlast_i (blko_tlast_o),
  .blko_tdata_i (blko_tdata_o),
  .crc_error_i  (crc_error_o),
  .overflow_i   (overflow_o)
);

//--- bench/usb_rx_core_tb.sv
`timescale 1ns/10ps

module usb_rx_core_tb;

  localparam int WAIT_LIMIT = 4000;  // Cycles a test may take to drain
  localparam int QUIET_LEN  = 12;

  logic       ulpi_clock;
  logic       arst_n;
  logic       ulpi_dir;
  logic       ulpi_nxt;
  logic [7:0] ulpi_data;
  logic       blko_tvalid;
  logic       blko_tready;
  logic       blko_tlast;
  logic [7:0] blko_tdata;
  logic       crc_error;
  logic       overflow;

  int    fd;
  int    tready_mode;   // 0 always ready, 1 random, 2 held low
  int    list_q[$];     // Words of one stimulus list, -1 marks an RX CMD cycle
  int    pkt_q[$];
  int    exp_data[$];
  int    exp_last[$];
  int    got_data[$];
  int    got_last[$];
  int    crc_cnt = 0;
  int    ov_cnt = 0;
  int    got_base;
  int    crc_base;
  int    ov_base;
  int    exp_crc;
  int    exp_ov;
  int    errors = 0;
  int    tests = 0;
  int    failed_tests = 0;
  string test_name;

  usb_rx_core usb_rx_core_inst (
    .ulpi_clock_i (ulpi_clock),
    .arst_n_i     (arst_n),
    .ulpi_dir_i   (ulpi_dir),
    .ulpi_nxt_i   (ulpi_nxt),
    .ulpi_data_i  (ulpi_data),
    .blko_tvalid_o(blko_tvalid),
    .blko_tready_i(blko_tready),
    .blko_tlast_o (blko_tlast),
    .blko_tdata_o (blko_tdata),
    .crc_error_o  (crc_error),
    .overflow_o   (overflow)
  );

  initial ulpi_clock = 1'b0;
  always #5 ulpi_clock = ~ulpi_clock;

  initial begin
    int seed_r;
    seed_r = $urandom(78);  // Same tready pattern on every run
    forever begin
      @(posedge ulpi_clock);
      #1;
      case (tready_mode)
        0: blko_tready = 1'b1;
        1: blko_tready = ($urandom & 1) != 0;
        default: blko_tready = 1'b0;
      endcase
    end
  end

  // Handshake seen here completes on the next rising edge
  always @(negedge ulpi_clock) begin
    if (arst_n) begin
      if (blko_tvalid && blko_tready) begin
        got_data.push_back(blko_tdata);
        got_last.push_back(blko_tlast);
      end
      if (crc_error) crc_cnt++;
      if (overflow) ov_cnt++;
    end
  end

  task automatic drive_pins(input logic dir, input logic nxt, input logic [7:0] data);
    @(posedge ulpi_clock);
    #1;
    ulpi_dir  = dir;
    ulpi_nxt  = nxt;
    ulpi_data = data;
  endtask

  task automatic send_packet();
    drive_pins(1'b1, 1'b0, 8'h00);  // Turnaround
    foreach (pkt_q[i]) begin
      if (pkt_q[i] < 0) begin
        drive_pins(1'b1, 1'b0, 8'h5d);  // RX CMD with RxActive
      end else begin
        drive_pins(1'b1, 1'b1, 8'(pkt_q[i]));
      end
    end
    repeat (5) drive_pins(1'b0, 1'b0, 8'h00);  // Bus back to link, pipeline settles
  endtask

  task automatic read_list();
    string w;
    int    v;
    int    r;
    list_q.delete();
    r = $fscanf(fd, "%s", w);
    while (r == 1 && w != ".") begin
      if (w == "R") begin
        list_q.push_back(-1);
      end else begin
        r = $sscanf(w, "%h", v);
        list_q.push_back(v);
      end
      r = $fscanf(fd, "%s", w);
    end
  endtask

  task automatic finish_test();
    int quiet;
    int cycles;
    int n;
    int errors_before;
    errors_before = errors;
    if (tready_mode == 2) tready_mode = 0;  // Release the stalled stream
    quiet  = 0;
    cycles = 0;
    while (quiet < QUIET_LEN && cycles < WAIT_LIMIT) begin
      @(negedge ulpi_clock);
      cycles++;
      if (got_data.size() >= got_base + exp_data.size() && !blko_tvalid) quiet++;
      else quiet = 0;
    end
    assert (quiet >= QUIET_LEN) else begin
      $display("test %s: stream did not go idle within %0d cycles", test_name, WAIT_LIMIT);
      errors++;
    end
    n = got_data.size() - got_base;
    assert (n == exp_data.size()) else begin
      $display("mismatch test %s byte count expected %0d actual %0d",
               test_name, exp_data.size(), n);
      errors++;
    end
    for (int i = 0; i < n && i < exp_data.size(); i++) begin
      assert (got_data[got_base + i] == exp_data[i]) else begin
        $display("mismatch test %s byte %0d expected %02h actual %02h",
                 test_name, i, exp_data[i], got_data[got_base + i]);
        errors++;
      end
      assert (got_last[got_base + i] == exp_last[i]) else begin
        $display("mismatch test %s tlast at byte %0d expected %0d actual %0d",
                 test_name, i, exp_last[i], got_last[got_base + i]);
        errors++;
      end
    end
    assert (crc_cnt - crc_base == exp_crc) else begin
      $display("mismatch test %s crc errors expected %0d actual %0d",
               test_name, exp_crc, crc_cnt - crc_base);
      errors++;
    end
    assert (ov_cnt - ov_base == exp_ov) else begin
      $display("mismatch test %s overflows expected %0d actual %0d",
               test_name, exp_ov, ov_cnt - ov_base);
      errors++;
    end
    tests++;
    if (errors != errors_before) failed_tests++;
    $display("test %-10s %s  bytes %0d  crc errors %0d  overflows %0d", test_name,
             (errors == errors_before) ? "passed" : "FAILED", n,
             crc_cnt - crc_base, ov_cnt - ov_base);
  endtask

  initial begin
    string w;
    string mode;
    string line;
    int    r;
    arst_n      = 1'b0;
    ulpi_dir    = 1'b0;
    ulpi_nxt    = 1'b0;
    ulpi_data   = 8'h00;
    blko_tready = 1'b0;
    tready_mode = 2;
    fd = $fopen("bench/usb_rx_input.txt", "r");
    repeat (4) @(posedge ulpi_clock);
    #1 arst_n = 1'b1;
    repeat (2) @(posedge ulpi_clock);
    if (fd == 0) begin
      $display("could not open the stimulus file bench/usb_rx_input.txt");
      errors++;
    end else begin
      r = $fscanf(fd, "%s", w);
      while (r == 1) begin
        if (w == "#") begin
          r = $fgets(line, fd);
        end else if (w == "test") begin
          r = $fscanf(fd, "%s %s %d %d", test_name, mode, exp_crc, exp_ov);
          tready_mode = (mode == "random") ? 1 : (mode == "hold") ? 2 : 0;
          exp_data.delete();
          exp_last.delete();
          got_base = got_data.size();
          crc_base = crc_cnt;
          ov_base  = ov_cnt;
        end else if (w == "pkt") begin
          read_list();
          pkt_q = list_q;
          send_packet();
        end else if (w == "exp") begin
          read_list();
          foreach (list_q[i]) begin
            exp_data.push_back(list_q[i]);
            exp_last.push_back(i == list_q.size() - 1);  // tlast on the packet's final byte
          end
        end else if (w == "end") begin
          finish_test();
        end else begin
          $display("unknown word %s in the stimulus file", w);
          errors++;
        end
        r = $fscanf(fd, "%s", w);
      end
      $fclose(fd);
    end
    $display("%0d tests run, %0d failed, %0d failed checks", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- bench/usb_rx_input.txt
# test <name> <tready: always random hold> <crc errors> <overflows> ... end
# pkt <ULPI bytes incl. CRC16, R = RX CMD cycle> .   exp <payload bytes of one packet> .
test good_out always 0 0
pkt E1 80 00 .
pkt C3 00 00 FE R 4F FE 4F FE 4F .
exp 00 00 FE 4F FE 4F .
end
test crc_bad always 1 0
pkt E1 80 00 .
pkt C3 00 00 FE 4F FE 4E .
end
test not_ours always 0 0
pkt E1 00 01 .
pkt C3 00 00 FE 4F .
pkt F1 80 00 .
pkt 4B 00 00 FE 4F .
end
test burst random 0 0
pkt E1 80 00 .
pkt C3 00 00 FE 4F .
pkt E1 80 00 .
pkt 4B 00 00 FE 4F FE 4F .
pkt E1 80 00 .
pkt C3 00 00 FE 4F FE 4F FE 4F .
exp 00 00 .
exp 00 00 FE 4F .
exp 00 00 FE 4F FE 4F .
end
test overflow hold 0 1
pkt E1 80 00 .
pkt C3 00 00 FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F
    FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F .
pkt E1 80 00 .
pkt 4B 00 00 FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F
    FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F .
pkt E1 80 00 .
pkt C3 00 00 FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F
    FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F .
exp 00 00 FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F
    FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F .
exp 00 00 FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F
    FE 4F FE 4F FE 4F FE 4F FE 4F FE 4F .
end

//--- files.f
+incdir+verilog
verilog/usb_rx_pkg.sv
verilog/ulpi_rx_decode.sv
verilog/usb_crc16.sv
verilog/usb_packet_exec.sv
verilog/usb_bulk_out_buffer.sv
verilog/usb_rx_core.sv
bench/usb_rx_core_properties.sv
bench/usb_rx_core_tb.sv

//--- verilog/ulpi_rx_decode.sv
`timescale 1ns/10ps

module ulpi_rx_decode
  import usb_rx_pkg::*;
(
  input  logic       ulpi_clock_i,
  input  logic       arst_n_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic [7:0] ulpi_data_i,
  output rx_beat_t   rx_beat_o
);

  typedef enum logic [1:0] {
    ST_IDLE,  // Link owns the bus
    ST_HOLD,  // PHY owns the bus, no packet byte yet
    ST_PKT    // Packet bytes flowing, one byte held back
  } dec_state_e;

  dec_state_e state_q;
  logic [7:0] hold_q;
  logic       hold_first_q;
  logic       take_byte;
  rx_beat_t   beat_q;

  // nxt low with dir high is an RX CMD and gets skipped
  assign take_byte = ulpi_dir_i && ulpi_nxt_i && (state_q == ST_HOLD || state_q == ST_PKT);

  always_ff @(posedge ulpi_clock_i) begin
    if (take_byte) begin
      hold_q <= ulpi_data_i;
    end
  end

  always_ff @(posedge ulpi_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= ST_IDLE;
      hold_first_q <= 1'b0;
      beat_q       <= '0;
    end else begin
      beat_q <= '0;
      case (state_q)
        ST_IDLE: begin
          if (ulpi_dir_i) begin
            state_q <= ST_HOLD;  // Turnaround cycle, data is not driven yet
          end
        end
        ST_HOLD: begin
          if (!ulpi_dir_i) begin
            state_q <= ST_IDLE;
          end else if (ulpi_nxt_i) begin
            state_q      <= ST_PKT;
            hold_first_q <= 1'b1;
          end
        end
        ST_PKT: begin
          if (!ulpi_dir_i) begin
            // Bus handed back, so the held byte ends the packet
            beat_q  <= '{valid: 1'b1, first: hold_first_q, last: 1'b1, data: hold_q};
            state_q <= ST_IDLE;
          end else if (ulpi_nxt_i) begin
            beat_q       <= '{valid: 1'b1, first: hold_first_q, last: 1'b0, data: hold_q};
            hold_first_q <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign rx_beat_o = beat_q;

endmodule

//--- verilog/usb_bulk_out_buffer.sv
`timescale 1ns/10ps
`include "usb_rx_consts.svh"

module usb_bulk_out_buffer
  import usb_rx_pkg::*;
(
  input  logic        ulpi_clock_i,
  input  logic        arst_n_i,
  input  rx_beat_t    pay_beat_i,
  input  pkt_status_t pkt_status_i,
  output logic        blko_tvalid_o,
  input  logic        blko_tready_i,
  output logic        blko_tlast_o,
  output logic [7:0]  blko_tdata_o,
  output logic        overflow_o
);

  localparam int DEPTH = `USB_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int LW    = $clog2(`USB_MAX_PKT + 1);

  logic [8:0]    mem [DEPTH];  // {eop, data}
  logic [AW:0]   wr_q;         // Next free entry of the packet in flight
  logic [AW:0]   cmt_q;        // End of committed packets
  logic [AW:0]   rd_q;
  logic [LW-1:0] len_q;
  logic          spoil_q;
  logic [AW:0]   used;
  logic          full;
  logic [LW-1:0] cur_len;
  logic          cur_spoil;
  logic          accept;
  logic          commit;
  logic [8:0]    rd_entry;

  assign used      = wr_q - rd_q;
  assign full      = (used == (AW + 1)'(DEPTH));
  assign cur_len   = pay_beat_i.first ? '0 : len_q;  // New packet starts counting afresh
  assign cur_spoil = pay_beat_i.first ? 1'b0 : spoil_q;
  assign accept    = pay_beat_i.valid && !cur_spoil && !full &&
                     (cur_len < LW'(`USB_MAX_PKT));
  assign commit    = pkt_status_i.done && pkt_status_i.good && pkt_status_i.ours && !spoil_q;

  always_ff @(posedge ulpi_clock_i) begin
    if (accept) begin
      mem[wr_q[AW-1:0]] <= {pay_beat_i.last, pay_beat_i.data};
    end
  end

  always_ff @(posedge ulpi_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_q    <= '0;
      cmt_q   <= '0;
      rd_q    <= '0;
      len_q   <= '0;
      spoil_q <= 1'b0;
    end else begin
      if (pkt_status_i.done) begin
        if (commit) begin
          cmt_q <= wr_q;
        end else begin
          wr_q <= cmt_q;  // Roll back the rejected packet
        end
        len_q   <= '0;
        spoil_q <= 1'b0;
      end else if (pay_beat_i.valid) begin
        if (accept) begin
          wr_q    <= wr_q + 1'b1;
          len_q   <= cur_len + 1'b1;
          spoil_q <= 1'b0;
        end else begin
          spoil_q <= 1'b1;  // No room or too long
        end
      end
      if (blko_tvalid_o && blko_tready_i) begin
        rd_q <= rd_q + 1'b1;
      end
    end
  end

  // Unread entries sit below the write region, so they stay put while stalled
  assign rd_entry      = mem[rd_q[AW-1:0]];
  assign blko_tvalid_o = (rd_q != cmt_q);
  assign blko_tlast_o  = blko_tvalid_o && rd_entry[8];
  assign blko_tdata_o  = rd_entry[7:0];

  // Only a packet that would otherwise have been delivered counts as lost
  assign overflow_o = pkt_status_i.done && pkt_status_i.good && pkt_status_i.ours && spoil_q;

endmodule

//--- verilog/usb_crc16.sv
`timescale 1ns/10ps

module usb_crc16 (
  input  logic       ulpi_clock_i,
  input  logic       arst_n_i,
  input  logic       clear_i,
  input  logic       en_i,
  input  logic [7:0] data_i,
  output logic       residue_ok_o
);

  localparam logic [15:0] POLY_REFL = 16'hA001;  // x^16 + x^15 + x^2 + 1, bit reversed
  localparam logic [15:0] RESIDUE   = 16'hB001;  // 0x800D as held in the reflected register

  logic [15:0] crc_q;

  // Bytes go out LSB first, so shift right through the reflected polynomial
  function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] d);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ POLY_REFL;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge ulpi_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_q <= 16'hFFFF;
    end else if (clear_i) begin
      crc_q <= 16'hFFFF;  // Preset to all ones
    end else if (en_i) begin
      crc_q <= crc_byte(crc_q, data_i);
    end
  end

  assign residue_ok_o = (crc_q == RESIDUE);

endmodule

//--- verilog/usb_packet_exec.sv
`timescale 1ns/10ps
`include "usb_rx_consts.svh"

module usb_packet_exec
  import usb_rx_pkg::*;
#(
  parameter logic [6:0] DEV_ADDR = `USB_DEF_ADDR,
  parameter logic [3:0] ENDPOINT = `USB_DEF_ENDP
) (
  input  logic        ulpi_clock_i,
  input  logic        arst_n_i,
  input  rx_beat_t    rx_beat_i,
  output rx_beat_t    pay_beat_o,
  output pkt_status_t pkt_status_o,
  output logic        crc_error_o
);

  typedef enum logic [2:0] {
    EX_IDLE,
    EX_TOK1,  // ADDR and ENDP bit 0
    EX_TOK2,  // ENDP bits 3:1 and CRC5
    EX_DATA,
    EX_SKIP   // Drop bytes up to the packet end
  } ex_state_e;

  ex_state_e  state_q;
  logic       armed_q;  // Last token was an OUT to us
  logic       done_q;
  logic [7:0] tok_q;
  logic [1:0] dly_cnt_q;
  logic       pay_first_q;
  logic [7:0] dly0_q;
  logic [7:0] dly1_q;
  usb_pid_e   pid;
  logic       pid_ok;
  logic       is_start;
  logic       is_body;
  logic       crc_en;
  logic       pay_fire;
  logic       tok_match;
  logic       residue_ok;

  assign pid       = usb_pid_e'(rx_beat_i.data[3:0]);
  assign pid_ok    = (rx_beat_i.data[7:4] == ~rx_beat_i.data[3:0]);
  assign is_start  = rx_beat_i.valid && rx_beat_i.first;
  assign is_body   = rx_beat_i.valid && !rx_beat_i.first;
  assign crc_en    = is_body && (state_q == EX_DATA);
  assign pay_fire  = crc_en && (dly_cnt_q == 2'd2);  // Two bytes held back, those may be the CRC
  assign tok_match = (tok_q[6:0] == DEV_ADDR) && ({rx_beat_i.data[2:0], tok_q[7]} == ENDPOINT);

  usb_crc16 crc16_inst (
    .ulpi_clock_i(ulpi_clock_i),
    .arst_n_i    (arst_n_i),
    .clear_i     (is_start),
    .en_i        (crc_en),
    .data_i      (rx_beat_i.data),
    .residue_ok_o(residue_ok)
  );

  always_ff @(posedge ulpi_clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= EX_IDLE;
      armed_q     <= 1'b0;
      done_q      <= 1'b0;
      dly_cnt_q   <= 2'd0;
      pay_first_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (done_q) begin
        armed_q <= 1'b0;  // One DATA packet per OUT token
      end
      if (is_start) begin
        dly_cnt_q   <= 2'd0;
        pay_first_q <= 1'b1;
        state_q     <= EX_SKIP;  // Bad PID lands here too
        if (pid_ok) begin
          case (pid)
            PID_OUT: begin
              armed_q <= 1'b0;
              state_q <= EX_TOK1;
            end
            PID_IN, PID_SETUP: armed_q <= 1'b0;
            PID_DATA0, PID_DATA1: state_q <= EX_DATA;  // Toggle not tracked
            default: state_q <= EX_SKIP;
          endcase
        end
        if (rx_beat_i.last) begin
          state_q <= EX_IDLE;
        end
      end else if (is_body) begin
        case (state_q)
          EX_TOK1: state_q <= EX_TOK2;
          EX_TOK2: begin
            armed_q <= tok_match;
            state_q <= EX_SKIP;
          end
          EX_DATA: begin
            if (dly_cnt_q != 2'd2) begin
              dly_cnt_q <= dly_cnt_q + 2'd1;
            end
            if (pay_fire) begin
              pay_first_q <= 1'b0;
            end
            done_q <= rx_beat_i.last;
          end
          default: state_q <= state_q;
        endcase
        if (rx_beat_i.last) begin
          state_q <= EX_IDLE;
        end
      end
    end
  end

  always_ff @(posedge ulpi_clock_i) begin
    if (is_body && state_q == EX_TOK1) begin
      tok_q <= rx_beat_i.data;
    end
    if (crc_en) begin
      dly1_q <= dly0_q;
      dly0_q <= rx_beat_i.data;
    end
  end

  // Payload leaves in the same cycle as the byte two positions behind it
  assign pay_beat_o   = '{valid: pay_fire, first: pay_first_q, last: rx_beat_i.last,
                          data: dly1_q};
  assign pkt_status_o = '{done: done_q, good: residue_ok, ours: armed_q};
  assign crc_error_o  = done_q && !residue_ok;

endmodule

//--- verilog/usb_rx_consts.svh
`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// Bulk-out buffer size in bytes, must be a power of two
`define USB_FIFO_DEPTH 64

// Largest DATA payload accepted, longer packets count as overflow
`define USB_MAX_PKT 32

// Default device address after bus reset
`define USB_DEF_ADDR 7'd0

// Bulk OUT endpoint number
`define USB_DEF_ENDP 4'd1

`endif

//--- verilog/usb_rx_core.sv
`timescale 1ns/10ps
`include "usb_rx_consts.svh"

module usb_rx_core
  import usb_rx_pkg::*;
#(
  parameter logic [6:0] DEV_ADDR = `USB_DEF_ADDR,
  parameter logic [3:0] ENDPOINT = `USB_DEF_ENDP
) (
  input  logic       ulpi_clock_i,
  input  logic       arst_n_i,

  // ULPI receive pins
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic [7:0] ulpi_data_i,

  // Bulk OUT endpoint stream
  output logic       blko_tvalid_o,
  input  logic       blko_tready_i,
  output logic       blko_tlast_o,
  output logic [7:0] blko_tdata_o,

  output logic       crc_error_o,
  output logic       overflow_o
);

  rx_beat_t    rx_beat;
  rx_beat_t    pay_beat;
  pkt_status_t pkt_status;

  ulpi_rx_decode ulpi_rx_decode_inst (
    .ulpi_clock_i(ulpi_clock_i),
    .arst_n_i    (arst_n_i),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_i (ulpi_data_i),
    .rx_beat_o   (rx_beat)
  );

  usb_packet_exec #(
    .DEV_ADDR(DEV_ADDR),
    .ENDPOINT(ENDPOINT)
  ) usb_packet_exec_inst (
    .ulpi_clock_i(ulpi_clock_i),
    .arst_n_i    (arst_n_i),
    .rx_beat_i   (rx_beat),
    .pay_beat_o  (pay_beat),      // CRC bytes already stripped
    .pkt_status_o(pkt_status),
    .crc_error_o (crc_error_o)
  );

  usb_bulk_out_buffer usb_bulk_out_buffer_inst (
    .ulpi_clock_i (ulpi_clock_i),
    .arst_n_i     (arst_n_i),
    .pay_beat_i   (pay_beat),
    .pkt_status_i (pkt_status),
    .blko_tvalid_o(blko_tvalid_o),
    .blko_tready_i(blko_tready_i),
    .blko_tlast_o (blko_tlast_o),
    .blko_tdata_o (blko_tdata_o),
    .overflow_o   (overflow_o)
  );

endmodule

//--- verilog/usb_rx_pkg.sv
package usb_rx_pkg;

  // PID codes in the low nibble, the high nibble carries the complement on the wire
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010
  } usb_pid_e;

  // One received byte with its framing
  typedef struct packed {
    logic       valid;
    logic       first;  // First byte of a packet
    logic       last;   // Final byte, dir dropped after it
    logic [7:0] data;
  } rx_beat_t;

  // End-of-packet verdict for a DATA packet
  typedef struct packed {
    logic done;  // One cycle pulse
    logic good;  // CRC16 residue matched
    logic ours;  // Packet followed a matching OUT token
  } pkt_status_t;

endpackage
